//--- hw/l1_cfg.svh
// L1 cache geometry macros: address, word, tag, index, offset and line sizes
`ifndef L1_CFG_SVH
`define L1_CFG_SVH

// Address split is tag | index | byte offset
`define L1_ADDR_W   32
`define L1_WORD_W   32

`define L1_TAG_W    20              // Upper address bits
`define L1_INDEX_W  8               // Selects one of the lines
`define L1_OFFSET_W 4               // Byte within a line

// Four words per line
`define L1_LINE_W   128
`define L1_LINES    256

`endif

//--- hw/cache_pkg.sv
// Cache datapath types: address fields, word, line and controller states
`include "l1_cfg.svh"

package cache_pkg;

    typedef logic [`L1_ADDR_W-1:0]  addr_t;     // Byte address from core or bus
    typedef logic [`L1_TAG_W-1:0]   tag_t;
    typedef logic [`L1_INDEX_W-1:0] index_t;
    typedef logic [`L1_WORD_W-1:0]  word_t;
    typedef logic [`L1_LINE_W-1:0]  line_t;     // Word 0 in the low bits

    // Controller FSM states
    typedef enum logic [2:0] {
        IDLE,                                   // Arbitrate snoop, flush, core
        LOOKUP,                                 // Tag compare on port A
        FILL_WAIT,                              // Waiting for the CCU
        UPDATE,                                 // Core done cycle
        FLUSH_WALK,                             // One index per cycle
        SNOOP                                   // Snoop ack cycle
    } ctrl_state_t;

endpackage

//--- hw/coherence_pkg.sv
// Coherence types: MESI line state, snoop kind and fill request kind
`include "l1_cfg.svh"

package coherence_pkg;

    // Encoding shared with the CCU
    typedef enum logic [1:0] {
        M = 2'b00,                              // Modified
        E = 2'b01,                              // Exclusive
        S = 2'b10,                              // Shared
        I = 2'b11                               // Invalid
    } mesi_t;

    // What another cache is doing to a line we may hold
    typedef enum logic {
        SNOOP_READ  = 1'b0,                     // Remote read, drop to S
        SNOOP_INVAL = 1'b1                      // Remote write, drop to I
    } snoop_kind_t;

    // Request kind towards the CCU
    typedef enum logic {
        FILL_READ    = 1'b0,                    // Full line plus state
        FILL_UPGRADE = 1'b1                     // Ownership only, S to M
    } fill_kind_t;

endpackage

//--- hw/line_store.sv
// Line store: tag, MESI state and data arrays with two read ports and two write ports
`timescale 1ns/1ns
`include "l1_cfg.svh"

module line_store (
    input  logic                 clk,
    input  logic                 rst,
    // Port A, controller side
    input  cache_pkg::index_t    a_index,
    output cache_pkg::tag_t      a_tag,
    output coherence_pkg::mesi_t a_state,
    output cache_pkg::line_t     a_line,
    input  logic                 a_we,
    input  cache_pkg::tag_t      a_wtag,
    input  coherence_pkg::mesi_t a_wstate,
    input  cache_pkg::line_t     a_wline,
    // Port B, snoop side
    input  cache_pkg::index_t    b_index,
    output cache_pkg::tag_t      b_tag,
    output coherence_pkg::mesi_t b_state,
    output cache_pkg::line_t     b_line,
    input  logic                 b_state_we,
    input  coherence_pkg::mesi_t b_wstate
);

    cache_pkg::tag_t      tag_mem   [`L1_LINES];
    coherence_pkg::mesi_t state_mem [`L1_LINES];
    cache_pkg::line_t     data_mem  [`L1_LINES];

    // Asynchronous reads on both ports
    assign a_tag   = tag_mem[a_index];
    assign a_state = state_mem[a_index];
    assign a_line  = data_mem[a_index];

    assign b_tag   = tag_mem[b_index];
    assign b_state = state_mem[b_index];
    assign b_line  = data_mem[b_index];

    // MESI array, every line comes up invalid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `L1_LINES; i++) begin
                state_mem[i] <= coherence_pkg::I;
            end
        end else begin
            if (a_we) begin
                state_mem[a_index] <= a_wstate;
            end
            if (b_state_we) begin
                state_mem[b_index] <= b_wstate;   // Snoop downgrade
            end
        end
    end

    // Tag and data only change through port A
    always_ff @(posedge clk) begin
        if (a_we) begin
            tag_mem[a_index]  <= a_wtag;
            data_mem[a_index] <= a_wline;
        end
    end

    // Controller and snoop unit must never write in the same cycle
    a_single_writer: assert property (
        @(posedge clk) disable iff (rst)
        !(a_we && b_state_we)
    ) else $error("line_store: port A and port B write in the same cycle");

endmodule

//--- hw/snoop_unit.sv
// Snoop unit: tag check, word select and MESI downgrade for bus snoops
`timescale 1ns/1ns
`include "l1_cfg.svh"

module snoop_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        snoop_grant,
    input  cache_pkg::addr_t            snoop_addr,
    input  coherence_pkg::snoop_kind_t  snoop_kind,
    output cache_pkg::index_t           b_index,
    input  cache_pkg::tag_t             b_tag,
    input  coherence_pkg::mesi_t        b_state,
    input  cache_pkg::line_t            b_line,
    output logic                        b_state_we,
    output coherence_pkg::mesi_t        b_wstate,
    output logic                        snoop_ack,
    output logic                        snoop_hit,
    output cache_pkg::word_t            snoop_data
);

    cache_pkg::tag_t  snoop_tag;
    logic [1:0]       word_sel;
    logic             tag_hit;
    cache_pkg::word_t sel_word;

    assign snoop_tag = snoop_addr[`L1_ADDR_W-1 -: `L1_TAG_W];
    assign b_index   = snoop_addr[`L1_OFFSET_W +: `L1_INDEX_W];
    assign word_sel  = snoop_addr[`L1_OFFSET_W-1:2];          // Word within the line

    assign tag_hit  = (b_tag == snoop_tag) && (b_state != coherence_pkg::I);
    assign sel_word = b_line[word_sel*`L1_WORD_W +: `L1_WORD_W];

    // New state lands on the same edge that raises snoop_ack
    assign b_state_we = snoop_grant && tag_hit;

    always_comb begin
        if (snoop_kind == coherence_pkg::SNOOP_INVAL) begin
            b_wstate = coherence_pkg::I;
        end else begin
            b_wstate = coherence_pkg::S;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snoop_ack <= 1'b0;
            snoop_hit <= 1'b0;
        end else begin
            snoop_ack <= snoop_grant;                         // One cycle after grant
            snoop_hit <= snoop_grant && tag_hit;
        end
    end

    // Data held until the next grant
    always_ff @(posedge clk) begin
        if (snoop_grant) begin
            snoop_data <= tag_hit ? sel_word : '0;
        end
    end

    // One ack per snoop needs a single-cycle grant
    a_grant_pulse: assert property (
        @(posedge clk) disable iff (rst)
        snoop_grant |=> !snoop_grant
    ) else $error("snoop_unit: snoop_grant held for more than one cycle");

endmodule

//--- hw/cache_ctrl.sv
// Cache controller FSM: core lookup, CCU fills and upgrades, flush walk, snoop arbitration
`timescale 1ns/1ns
`include "l1_cfg.svh"

module cache_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    // Core
    input  logic                       core_req,
    input  logic                       core_we,
    input  cache_pkg::addr_t           core_addr,
    input  cache_pkg::word_t           core_wdata,
    output logic                       core_done,
    output logic                       core_hit,
    output cache_pkg::word_t           core_rdata,
    // CCU
    output logic                       fill_req,
    output cache_pkg::addr_t           fill_addr,
    output coherence_pkg::fill_kind_t  fill_kind,
    input  logic                       fill_ready,
    input  cache_pkg::line_t           fill_data,
    input  coherence_pkg::mesi_t       fill_state,
    // Flush and snoop
    input  logic                       flush_req,
    output logic                       flush_done,
    input  logic                       snoop_req,
    output logic                       snoop_grant,
    // Line store port A
    output cache_pkg::index_t          a_index,
    input  cache_pkg::tag_t            a_tag,
    input  coherence_pkg::mesi_t       a_state,
    input  cache_pkg::line_t           a_line,
    output logic                       a_we,
    output cache_pkg::tag_t            a_wtag,
    output coherence_pkg::mesi_t       a_wstate,
    output cache_pkg::line_t           a_wline
);

    cache_pkg::ctrl_state_t     state;
    cache_pkg::ctrl_state_t     next_state;
    cache_pkg::index_t          flush_idx;
    cache_pkg::tag_t            core_tag;
    cache_pkg::index_t          core_index;
    logic [1:0]                 word_sel;
    logic                       lookup_hit;
    logic                       hit_q;
    logic                       last_index;
    coherence_pkg::fill_kind_t  fill_kind_q;

    // Replace one word of a line with the core write data
    function automatic cache_pkg::line_t merge_word(input cache_pkg::line_t line,
                                                    input logic [1:0] sel,
                                                    input cache_pkg::word_t wdata);
        cache_pkg::line_t res;
        res = line;
        res[sel*`L1_WORD_W +: `L1_WORD_W] = wdata;
        return res;
    endfunction

    assign core_tag   = core_addr[`L1_ADDR_W-1 -: `L1_TAG_W];
    assign core_index = core_addr[`L1_OFFSET_W +: `L1_INDEX_W];
    assign word_sel   = core_addr[`L1_OFFSET_W-1:2];

    assign a_index    = (state == cache_pkg::FLUSH_WALK) ? flush_idx : core_index;
    assign lookup_hit = (a_tag == core_tag) && (a_state != coherence_pkg::I);
    assign last_index = (flush_idx == cache_pkg::index_t'(`L1_LINES - 1));

    // Core and CCU handshakes
    assign core_done  = (state == cache_pkg::UPDATE);
    assign core_hit   = core_done && hit_q;
    assign core_rdata = a_line[word_sel*`L1_WORD_W +: `L1_WORD_W];   // Line already updated
    assign fill_req   = (state == cache_pkg::FILL_WAIT);
    assign fill_kind  = fill_kind_q;
    assign fill_addr  = {core_tag, core_index, {`L1_OFFSET_W{1'b0}}};

    // Write hit in M/E in LOOKUP, fill on fill_ready, invalidate in flush
    assign a_we = (state == cache_pkg::LOOKUP && lookup_hit && core_we
                   && a_state != coherence_pkg::S)
               || (state == cache_pkg::FILL_WAIT && fill_ready)
               || (state == cache_pkg::FLUSH_WALK);

    always_comb begin
        next_state  = state;
        snoop_grant = 1'b0;
        case (state)
            cache_pkg::IDLE: begin
                if (snoop_req) begin
                    snoop_grant = 1'b1;
                    next_state  = cache_pkg::SNOOP;
                end else if (flush_req && !flush_done) begin     // Not the done cycle
                    next_state = cache_pkg::FLUSH_WALK;
                end else if (core_req) begin
                    next_state = cache_pkg::LOOKUP;
                end
            end
            cache_pkg::LOOKUP: begin
                if (lookup_hit && (!core_we || a_state != coherence_pkg::S)) begin
                    next_state = cache_pkg::UPDATE;
                end else begin
                    next_state = cache_pkg::FILL_WAIT;          // Miss or upgrade
                end
            end
            cache_pkg::FILL_WAIT: begin
                if (fill_ready) begin
                    next_state = cache_pkg::UPDATE;
                end
            end
            cache_pkg::FLUSH_WALK: begin
                if (last_index) begin
                    next_state = cache_pkg::IDLE;
                end
            end
            cache_pkg::UPDATE,
            cache_pkg::SNOOP: next_state = cache_pkg::IDLE;
            default:          next_state = cache_pkg::IDLE;
        endcase
    end

    // Write data for port A
    always_comb begin
        a_wtag   = core_tag;
        a_wstate = coherence_pkg::M;
        a_wline  = merge_word(a_line, word_sel, core_wdata);
        case (state)
            cache_pkg::FLUSH_WALK: begin
                a_wtag   = a_tag;
                a_wstate = coherence_pkg::I;
                a_wline  = a_line;
            end
            cache_pkg::FILL_WAIT: begin
                if (fill_kind_q == coherence_pkg::FILL_READ) begin
                    if (core_we) begin
                        a_wline = merge_word(fill_data, word_sel, core_wdata);
                    end else begin
                        a_wline  = fill_data;
                        a_wstate = fill_state;                  // State granted by the CCU
                    end
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= cache_pkg::IDLE;
            flush_idx   <= '0;
            hit_q       <= 1'b0;
            fill_kind_q <= coherence_pkg::FILL_READ;
            flush_done  <= 1'b0;
        end else begin
            state      <= next_state;
            flush_done <= (state == cache_pkg::FLUSH_WALK) && last_index;
            if (state == cache_pkg::FLUSH_WALK) begin
                flush_idx <= flush_idx + 1'b1;                  // Wraps to 0 after the walk
            end
            if (state == cache_pkg::LOOKUP) begin
                hit_q <= lookup_hit;
                if (lookup_hit && core_we) begin
                    fill_kind_q <= coherence_pkg::FILL_UPGRADE;
                end else begin
                    fill_kind_q <= coherence_pkg::FILL_READ;
                end
            end
        end
    end

    // Request, address and kind stay put until the CCU answers
    a_fill_held: assert property (
        @(posedge clk) disable iff (rst)
        fill_req && !fill_ready |=> fill_req && $stable(fill_addr) && $stable(fill_kind)
    ) else $error("cache_ctrl: fill request changed before fill_ready");

endmodule

//--- hw/l1_cache_top.sv
// L1 data cache top: controller, line store and snoop unit
`timescale 1ns/1ns

module l1_cache_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        core_req,
    input  logic                        core_we,
    input  cache_pkg::addr_t            core_addr,
    input  cache_pkg::word_t            core_wdata,
    output logic                        core_done,
    output logic                        core_hit,
    output cache_pkg::word_t            core_rdata,
    output logic                        fill_req,
    output cache_pkg::addr_t            fill_addr,
    output coherence_pkg::fill_kind_t   fill_kind,
    input  logic                        fill_ready,
    input  cache_pkg::line_t            fill_data,
    input  coherence_pkg::mesi_t        fill_state,
    input  logic                        snoop_req,
    input  cache_pkg::addr_t            snoop_addr,
    input  coherence_pkg::snoop_kind_t  snoop_kind,
    output logic                        snoop_ack,
    output logic                        snoop_hit,
    output cache_pkg::word_t            snoop_data,
    input  logic                        flush_req,
    output logic                        flush_done
);

    logic                 snoop_grant;
    cache_pkg::index_t    a_index;
    cache_pkg::tag_t      a_tag;
    coherence_pkg::mesi_t a_state;
    cache_pkg::line_t     a_line;
    logic                 a_we;
    cache_pkg::tag_t      a_wtag;
    coherence_pkg::mesi_t a_wstate;
    cache_pkg::line_t     a_wline;
    cache_pkg::index_t    b_index;
    cache_pkg::tag_t      b_tag;
    coherence_pkg::mesi_t b_state;
    cache_pkg::line_t     b_line;
    logic                 b_state_we;
    coherence_pkg::mesi_t b_wstate;

    cache_ctrl u_ctrl (
        .clk, .rst,
        .core_req, .core_we, .core_addr, .core_wdata,
        .core_done, .core_hit, .core_rdata,
        .fill_req, .fill_addr, .fill_kind, .fill_ready, .fill_data, .fill_state,
        .flush_req, .flush_done, .snoop_req, .snoop_grant,
        .a_index, .a_tag, .a_state, .a_line,
        .a_we, .a_wtag, .a_wstate, .a_wline
    );

    line_store u_store (
        .clk, .rst,
        .a_index, .a_tag, .a_state, .a_line,
        .a_we, .a_wtag, .a_wstate, .a_wline,
        .b_index, .b_tag, .b_state, .b_line,
        .b_state_we, .b_wstate
    );

    snoop_unit u_snoop (
        .clk, .rst, .snoop_grant, .snoop_addr, .snoop_kind,
        .b_index, .b_tag, .b_state, .b_line, .b_state_we, .b_wstate,
        .snoop_ack, .snoop_hit, .snoop_data
    );

endmodule

//--- testbench/tb_l1_cache.sv
// Testbench for the L1 cache: clock, reset, CCU responder, reference model, compare tasks, watchdog
`timescale 1ns/1ns
`include "l1_cfg.svh"

module tb_l1_cache;

    localparam int TXN_TOTAL   = 8 + 20 + 20 + 9 + 400 + 5;  // Tests 1 to 6
    localparam int CYC_PER_TXN = 300;

    logic                       clk;
    logic                       rst;
    logic                       core_req;
    logic                       core_we;
    cache_pkg::addr_t           core_addr;
    cache_pkg::word_t           core_wdata;
    logic                       core_done;
    logic                       core_hit;
    cache_pkg::word_t           core_rdata;
    logic                       fill_req;
    cache_pkg::addr_t           fill_addr;
    coherence_pkg::fill_kind_t  fill_kind;
    logic                       fill_ready;
    cache_pkg::line_t           fill_data;
    coherence_pkg::mesi_t       fill_state;
    logic                       snoop_req;
    cache_pkg::addr_t           snoop_addr;
    coherence_pkg::snoop_kind_t snoop_kind;
    logic                       snoop_ack;
    logic                       snoop_hit;
    cache_pkg::word_t           snoop_data;
    logic                       flush_req;
    logic                       flush_done;

    integer                     seed;
    int                         errors = 0;
    int                         checks = 0;
    int                         core_ops = 0;
    int                         snoop_ops = 0;
    int                         flush_ops = 0;
    int                         core_pulses = 0;
    int                         snoop_pulses = 0;
    int                         flush_pulses = 0;
    int                         fill_count;                  // Fill requests seen per access
    int                         fill_delay;                  // Drawn by the stimulus thread
    coherence_pkg::mesi_t       fill_grant;
    coherence_pkg::fill_kind_t  seen_kind;
    cache_pkg::addr_t           seen_addr;

    // Reference model of the cache contents
    cache_pkg::tag_t            m_tag   [`L1_LINES];
    coherence_pkg::mesi_t       m_state [`L1_LINES];
    cache_pkg::line_t           m_line  [`L1_LINES];

    l1_cache_top DUT (.*);

    always #4 clk = ~clk;

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic cache_pkg::index_t index_of(input cache_pkg::addr_t a);
        return a[`L1_OFFSET_W +: `L1_INDEX_W];
    endfunction

    function automatic cache_pkg::tag_t tag_of(input cache_pkg::addr_t a);
        return a[`L1_ADDR_W-1 -: `L1_TAG_W];
    endfunction

    function automatic int word_of(input cache_pkg::addr_t a);
        return a[`L1_OFFSET_W-1:2];
    endfunction

    // Few tags over few indices so that lines conflict
    function automatic cache_pkg::addr_t pool_addr(input int t, input int i, input int w);
        cache_pkg::tag_t   tag;
        cache_pkg::index_t idx;
        tag = cache_pkg::tag_t'(20'hA_0000 + t * 20'h0_1357);
        idx = cache_pkg::index_t'(i * 8'h45 + 3);
        return {tag, idx, w[1:0], 2'b00};
    endfunction

    // Memory image behind the CCU
    function automatic cache_pkg::word_t pattern_word(input cache_pkg::addr_t a, input int w);
        cache_pkg::word_t base;
        base = {a[`L1_ADDR_W-1:`L1_OFFSET_W], 4'h0} + 32'(w * 4);
        return (base * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic cache_pkg::line_t pattern_line(input cache_pkg::addr_t a);
        cache_pkg::line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*`L1_WORD_W +: `L1_WORD_W] = pattern_word(a, w);
        end
        return line;
    endfunction

    task automatic compare_word(input string what, input cache_pkg::word_t got,
                                input cache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_state(input string what, input coherence_pkg::mesi_t got,
                                 input coherence_pkg::mesi_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s is %b, expected %s", $time, what, got, exp.name());
        end
    endtask

    task automatic compare_kind(input string what, input coherence_pkg::fill_kind_t got,
                                input coherence_pkg::fill_kind_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s is %b, expected %s", $time, what, got, exp.name());
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < `L1_LINES; i++) begin
            m_state[i] = coherence_pkg::I;
        end
    endtask

    // Grant is the state the CCU hands out on a read fill
    task automatic core_access(input logic we, input cache_pkg::addr_t addr,
                               input cache_pkg::word_t wdata,
                               input coherence_pkg::mesi_t grant);
        cache_pkg::index_t         idx;
        int                        w;
        int                        cycles;
        logic                      hit;
        logic                      need_fill;
        coherence_pkg::fill_kind_t kind;
        idx       = index_of(addr);
        w         = word_of(addr);
        hit       = (m_state[idx] != coherence_pkg::I) && (m_tag[idx] == tag_of(addr));
        need_fill = !hit || (we && m_state[idx] == coherence_pkg::S);
        kind      = (hit && we) ? coherence_pkg::FILL_UPGRADE : coherence_pkg::FILL_READ;
        if (need_fill && kind == coherence_pkg::FILL_READ) begin
            m_line[idx]  = pattern_line(addr);
            m_tag[idx]   = tag_of(addr);
            m_state[idx] = grant;
        end
        if (we) begin
            m_line[idx][w*`L1_WORD_W +: `L1_WORD_W] = wdata;
            m_state[idx] = coherence_pkg::M;
        end
        @(negedge clk);                                      // Idle cycle between requests
        fill_grant = grant;
        fill_delay = rnd(6);
        fill_count = 0;
        cycles     = 0;
        core_req   = 1'b1;
        core_we    = we;
        core_addr  = addr;
        core_wdata = wdata;
        do begin
            @(negedge clk);
            cycles++;
        end while (!core_done);
        core_ops++;
        compare_bit("core_hit", core_hit, hit);
        compare_word("core_rdata", core_rdata, m_line[idx][w*`L1_WORD_W +: `L1_WORD_W]);
        compare_word("fill request count", fill_count, need_fill);
        if (need_fill) begin
            compare_kind("fill_kind", seen_kind, kind);
            compare_word("fill_addr", seen_addr, {addr[`L1_ADDR_W-1:`L1_OFFSET_W], 4'h0});
        end else begin
            compare_word("hit latency", cycles, 2);
        end
        compare_state("line state", DUT.u_store.state_mem[idx], m_state[idx]);
        core_req = 1'b0;
    endtask

    task automatic bus_snoop(input coherence_pkg::snoop_kind_t kind,
                             input cache_pkg::addr_t addr);
        cache_pkg::index_t idx;
        cache_pkg::word_t  exp_data;
        int                cycles;
        logic              hit;
        idx      = index_of(addr);
        hit      = (m_state[idx] != coherence_pkg::I) && (m_tag[idx] == tag_of(addr));
        exp_data = hit ? m_line[idx][word_of(addr)*`L1_WORD_W +: `L1_WORD_W] : '0;
        if (hit) begin
            m_state[idx] = (kind == coherence_pkg::SNOOP_INVAL) ? coherence_pkg::I
                                                                : coherence_pkg::S;
        end
        @(negedge clk);
        snoop_req  = 1'b1;
        snoop_kind = kind;
        snoop_addr = addr;
        cycles     = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!snoop_ack);
        snoop_ops++;
        compare_bit("snoop_hit", snoop_hit, hit);
        compare_word("snoop_data", snoop_data, exp_data);
        compare_word("snoop latency", cycles, 1);
        compare_state("line state after snoop", DUT.u_store.state_mem[idx], m_state[idx]);
        snoop_req = 1'b0;
    endtask

    task automatic flush_lines();
        int cycles;
        @(negedge clk);
        flush_req = 1'b1;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!flush_done);
        flush_ops++;
        compare_word("flush latency", cycles, `L1_LINES + 1);
        for (int i = 0; i < `L1_LINES; i++) begin
            m_state[i] = coherence_pkg::I;
        end
        flush_req = 1'b0;
    endtask

    task automatic end_test(input string name, input int start);
        $display("%0t ns: test %-20s done, %0d errors", $time, name, errors - start);
    endtask

    // CCU model answering each fill after the drawn delay
    initial begin
        fill_ready = 1'b0;
        fill_data  = '0;
        fill_state = coherence_pkg::I;
        forever begin
            @(negedge clk);
            if (fill_req && !fill_ready) begin
                fill_count++;
                seen_kind = fill_kind;
                seen_addr = fill_addr;
                repeat (fill_delay) @(negedge clk);
                fill_data  = pattern_line(fill_addr);
                fill_state = (fill_kind == coherence_pkg::FILL_UPGRADE) ? coherence_pkg::M
                                                                        : fill_grant;
                fill_ready = 1'b1;
                @(negedge clk);
                fill_ready = 1'b0;
            end
        end
    end

    // Handshake pulse counters for the closing check
    always @(posedge clk) begin
        if (!rst) begin
            core_pulses  += core_done;
            snoop_pulses += snoop_ack;
            flush_pulses += flush_done;
        end
    end

    initial begin
        #((TXN_TOTAL * CYC_PER_TXN + 16) * 8);
        $display("Watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int start;
        seed       = 10;
        clk        = 1'b0;
        rst        = 1'b1;
        core_req   = 1'b0;
        core_we    = 1'b0;
        core_addr  = '0;
        core_wdata = '0;
        snoop_req  = 1'b0;
        snoop_addr = '0;
        snoop_kind = coherence_pkg::SNOOP_READ;
        flush_req  = 1'b0;
        apply_reset();

        start = errors;                                      // Miss fills then hit
        for (int i = 0; i < 4; i++) begin
            core_access(1'b0, pool_addr(0, i, i), '0, coherence_pkg::E);
            core_access(1'b0, pool_addr(0, i, i), '0, coherence_pkg::E);
        end
        end_test("read miss then hit", start);

        start = errors;                                      // Even indices fill in S
        for (int i = 0; i < 4; i++) begin
            core_access(1'b0, pool_addr(1, i, 0), '0,
                        (i % 2) ? coherence_pkg::E : coherence_pkg::S);
            core_access(1'b1, pool_addr(1, i, 1), $random(seed), coherence_pkg::E);
            core_access(1'b0, pool_addr(1, i, 1), '0, coherence_pkg::E);
            core_access(1'b1, pool_addr(2, i, 2), $random(seed), coherence_pkg::E);
            core_access(1'b0, pool_addr(2, i, 2), '0, coherence_pkg::E);
        end
        end_test("writes", start);

        start = errors;
        for (int i = 0; i < 4; i++) begin
            core_access(1'b0, pool_addr(3, i, i), '0, coherence_pkg::E);
            bus_snoop(coherence_pkg::SNOOP_READ, pool_addr(3, i, 3 - i));
            bus_snoop(coherence_pkg::SNOOP_READ, pool_addr(0, i, i));    // Other tag
            bus_snoop(coherence_pkg::SNOOP_INVAL, pool_addr(3, i, i));
            core_access(1'b0, pool_addr(3, i, i), '0, coherence_pkg::S);
        end
        end_test("snoops", start);

        start = errors;
        for (int i = 0; i < 4; i++) begin
            core_access(1'b0, pool_addr(1, i, 0), '0, coherence_pkg::E);
        end
        flush_lines();
        for (int i = 0; i < 4; i++) begin
            core_access(1'b0, pool_addr(1, i, 0), '0, coherence_pkg::E);
        end
        end_test("flush", start);

        start = errors;
        for (int n = 0; n < 400; n++) begin
            int               r;
            cache_pkg::addr_t a;
            r = rnd(100);
            a = pool_addr(rnd(4), rnd(4), rnd(4));
            if (r < 40) begin
                core_access(1'b0, a, '0, rnd(2) ? coherence_pkg::E : coherence_pkg::S);
            end else if (r < 75) begin
                core_access(1'b1, a, $random(seed),
                            rnd(2) ? coherence_pkg::E : coherence_pkg::S);
            end else if (r < 97) begin
                bus_snoop(coherence_pkg::snoop_kind_t'(rnd(2)), a);
            end else begin
                flush_lines();
            end
        end
        end_test("random mix", start);

        @(negedge clk);                                      // Last pulse reaches the counters
        start = errors;                                      // Everything misses again
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            core_access(1'b0, pool_addr(0, i, 0), '0, coherence_pkg::E);
        end
        bus_snoop(coherence_pkg::SNOOP_READ, pool_addr(2, 0, 0));
        end_test("reset", start);

        @(negedge clk);
        compare_word("core_done pulses", core_pulses, core_ops);
        compare_word("snoop_ack pulses", snoop_pulses, snoop_ops);
        compare_word("flush_done pulses", flush_pulses, flush_ops);
        $display("%0d checks, %0d errors, %0d core, %0d snoop, %0d flush transactions",
                 checks, errors, core_ops, snoop_ops, flush_ops);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/cache_pkg.sv
hw/coherence_pkg.sv
hw/line_store.sv
hw/snoop_unit.sv
hw/cache_ctrl.sv
hw/l1_cache_top.sv
testbench/tb_l1_cache.sv
